//--- design/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

  localparam int xlen = 32;
  localparam int reg_addr_w = 5;
  localparam int pc_w = xlen - 2; // Word-aligned PC

  // Major opcodes
  localparam logic [6:0] op_lui = 7'b0110111;
  localparam logic [6:0] op_imm = 7'b0010011;
  localparam logic [6:0] op_load = 7'b0000011;
  localparam logic [6:0] op_store = 7'b0100011;

  // Encoding follows OP-IMM funct3
  typedef enum logic [3:0] {
    alu_add = 4'd0,
    alu_sll = 4'd1,
    alu_slt = 4'd2,
    alu_sltu = 4'd3,
    alu_xor = 4'd4,
    alu_srl = 4'd5,
    alu_or = 4'd6,
    alu_and = 4'd7
  } alu_cmd_t;

endpackage

`default_nettype wire

//--- design/rv_bus_pkg.sv
`default_nettype none

package rv_bus_pkg;

  localparam int bus_addr_w = 30; // Word address
  localparam int bus_sel_w = 4;
  localparam logic [bus_sel_w-1:0] sel_full = '1;

endpackage

`default_nettype wire

//--- design/rv_fetch.sv
`timescale 1ns/10ps
`default_nettype none

module rv_fetch (
  input wire logic clk_i,
  input wire logic reset_ni,
  input wire logic instr_ready_i,
  output logic instr_valid_o,
  output logic [rv_isa_pkg::xlen-1:0] instr_o,
  output logic [rv_isa_pkg::pc_w-1:0] pc_o,
  input wire logic bus_ack_i,
  input wire logic bus_stall_i,
  input wire logic [rv_isa_pkg::xlen-1:0] bus_rdata_i,
  output logic bus_cyc_o,
  output logic bus_stb_o,
  output logic [rv_bus_pkg::bus_addr_w-1:0] bus_addr_o
);
  import rv_isa_pkg::*;

  logic [pc_w-1:0] pc_q;
  logic cyc_q;
  logic stb_q;
  logic take;
  logic done;

  assign take = instr_valid_o && instr_ready_i;
  assign done = cyc_q && bus_ack_i;

  assign bus_cyc_o = cyc_q;
  assign bus_stb_o = stb_q;
  assign bus_addr_o = pc_q;

  always_ff @(posedge clk_i) begin
    if (!reset_ni || done) begin
      cyc_q <= 1'b0;
      stb_q <= 1'b0;
    end else if (!cyc_q && !instr_valid_o) begin // Nothing held, go get it
      cyc_q <= 1'b1;
      stb_q <= 1'b1;
    end else if (cyc_q && !bus_stall_i) begin
      stb_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      instr_valid_o <= 1'b0;
      pc_q <= '0;
    end else if (done) begin
      instr_valid_o <= 1'b1;
    end else if (take) begin
      instr_valid_o <= 1'b0;
      pc_q <= pc_q + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (done) begin
      instr_o <= bus_rdata_i;
      pc_o <= pc_q;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module rv_regfile (
  input wire logic clk_i,
  input wire logic w_enable_i,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] w_addr_i,
  input wire logic [rv_isa_pkg::xlen-1:0] w_data_i,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] rd0_addr_i,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] rd1_addr_i,
  output logic [rv_isa_pkg::xlen-1:0] rd0_data_o,
  output logic [rv_isa_pkg::xlen-1:0] rd1_data_o
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] regs [2**reg_addr_w];

  // x0 always reads zero
  assign rd0_data_o = (rd0_addr_i == '0) ? '0 : regs[rd0_addr_i];
  assign rd1_data_o = (rd1_addr_i == '0) ? '0 : regs[rd1_addr_i];

  always_ff @(posedge clk_i) begin
    if (w_enable_i && w_addr_i != '0) begin
      regs[w_addr_i] <= w_data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_decode.sv
`timescale 1ns/10ps
`default_nettype none

module rv_decode (
  input wire logic clk_i,
  input wire logic reset_ni,
  input wire logic valid_i,
  input wire logic [rv_isa_pkg::xlen-1:0] instr_i,
  output logic ready_o,
  input wire logic ready_i,
  output logic valid_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_o,
  output rv_isa_pkg::alu_cmd_t alu_cmd_o,
  output logic [rv_isa_pkg::xlen-1:0] alu_lhs_o,
  output logic [rv_isa_pkg::xlen-1:0] alu_rhs_o,
  output logic mem_valid_o,
  output logic mem_we_o,
  output logic [rv_isa_pkg::xlen-1:0] mem_data_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rf_rd0_addr_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rf_rd1_addr_o,
  input wire logic [rv_isa_pkg::xlen-1:0] rf_rd0_data_i,
  input wire logic [rv_isa_pkg::xlen-1:0] rf_rd1_data_i,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] ex_rd_i,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] ls_rd_i,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] wb_rd_i,
  input wire logic wb_valid_i
);
  import rv_isa_pkg::*;

  logic [6:0] opcode;
  logic [reg_addr_w-1:0] rd;
  logic [reg_addr_w-1:0] rs1;
  logic [reg_addr_w-1:0] rs2;
  logic [2:0] funct3;
  logic [xlen-1:0] i_imm;
  logic [xlen-1:0] s_imm;
  logic [xlen-1:0] u_imm;
  logic [reg_addr_w-1:0] wb_rd;
  logic rs1_used;
  logic rs2_used;
  logic rs1_hit;
  logic rs2_hit;
  logic [reg_addr_w-1:0] rd_d;
  alu_cmd_t alu_cmd_d;
  logic [xlen-1:0] alu_lhs_d;
  logic [xlen-1:0] alu_rhs_d;
  logic mem_valid_d;
  logic mem_we_d;

  assign opcode = instr_i[6:0];
  assign rd = instr_i[11:7];
  assign funct3 = instr_i[14:12];
  assign rs1 = instr_i[19:15];
  assign rs2 = instr_i[24:20];

  assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
  assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign u_imm = {instr_i[31:12], 12'b0};

  assign rf_rd0_addr_o = rs1;
  assign rf_rd1_addr_o = rs2;

  always_comb begin
    rd_d = rd;
    alu_cmd_d = alu_add;
    alu_lhs_d = rf_rd0_data_i;
    alu_rhs_d = i_imm;
    mem_valid_d = 1'b0;
    mem_we_d = 1'b0;
    rs1_used = 1'b0;
    rs2_used = 1'b0;
    case (opcode)
      op_lui: begin
        alu_lhs_d = u_imm;
        alu_rhs_d = '0;
      end
      op_imm: begin
        alu_cmd_d = alu_cmd_t'({1'b0, funct3});
        rs1_used = 1'b1;
      end
      op_load: begin
        mem_valid_d = 1'b1;
        rs1_used = 1'b1;
      end
      op_store: begin
        mem_valid_d = 1'b1;
        mem_we_d = 1'b1;
        alu_rhs_d = s_imm;
        rd_d = '0; // Those bits are immediate
        rs1_used = 1'b1;
        rs2_used = 1'b1;
      end
      default: rd_d = '0;
    endcase
  end

  // RAW check against every stage not yet written back
  assign wb_rd = wb_valid_i ? wb_rd_i : '0;
  assign rs1_hit = rs1_used && rs1 != '0 && (rs1 == ex_rd_i || rs1 == ls_rd_i || rs1 == wb_rd);
  assign rs2_hit = rs2_used && rs2 != '0 && (rs2 == ex_rd_i || rs2 == ls_rd_i || rs2 == wb_rd);
  assign ready_o = ready_i && !(rs1_hit || rs2_hit);

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      valid_o <= 1'b0;
    end else if (ready_o) begin
      valid_o <= valid_i;
    end else if (ready_i) begin
      valid_o <= 1'b0; // Bubble while stalled
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_o) begin
      rd_addr_o <= rd_d;
      alu_cmd_o <= alu_cmd_d;
      alu_lhs_o <= alu_lhs_d;
      alu_rhs_o <= alu_rhs_d;
      mem_valid_o <= mem_valid_d;
      mem_we_o <= mem_we_d;
      mem_data_o <= rf_rd1_data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_execute.sv
`timescale 1ns/10ps
`default_nettype none

module rv_execute (
  input wire logic clk_i,
  input wire logic reset_ni,
  input wire logic valid_i,
  output logic ready_o,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_i,
  input wire rv_isa_pkg::alu_cmd_t alu_cmd_i,
  input wire logic [rv_isa_pkg::xlen-1:0] alu_lhs_i,
  input wire logic [rv_isa_pkg::xlen-1:0] alu_rhs_i,
  input wire logic mem_valid_i,
  input wire logic mem_we_i,
  input wire logic [rv_isa_pkg::xlen-1:0] mem_data_i,
  input wire logic ready_i,
  output logic valid_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_o,
  output logic [rv_isa_pkg::xlen-1:0] result_o,
  output logic mem_valid_o,
  output logic mem_we_o,
  output logic [rv_isa_pkg::xlen-1:0] mem_data_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0] hz_rd_o
);
  import rv_isa_pkg::*;

  logic [xlen-1:0] alu_res;

  assign ready_o = ready_i;
  assign hz_rd_o = valid_i ? rd_addr_i : '0;

  always_comb begin
    case (alu_cmd_i)
      alu_sll: alu_res = alu_lhs_i << alu_rhs_i[4:0];
      alu_slt: alu_res = {{(xlen-1){1'b0}}, $signed(alu_lhs_i) < $signed(alu_rhs_i)};
      alu_sltu: alu_res = {{(xlen-1){1'b0}}, alu_lhs_i < alu_rhs_i};
      alu_xor: alu_res = alu_lhs_i ^ alu_rhs_i;
      alu_srl: alu_res = alu_lhs_i >> alu_rhs_i[4:0];
      alu_or: alu_res = alu_lhs_i | alu_rhs_i;
      alu_and: alu_res = alu_lhs_i & alu_rhs_i;
      default: alu_res = alu_lhs_i + alu_rhs_i; // Also address calc
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      valid_o <= 1'b0;
    end else if (ready_i) begin
      valid_o <= valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ready_i) begin
      rd_addr_o <= rd_addr_i;
      result_o <= alu_res;
      mem_valid_o <= mem_valid_i;
      mem_we_o <= mem_we_i;
      mem_data_o <= mem_data_i;
    end
  end

endmodule

`default_nettype wire

//--- design/rv_lsu.sv
`timescale 1ns/10ps
`default_nettype none

module rv_lsu (
  input wire logic clk_i,
  input wire logic reset_ni,
  input wire logic valid_i,
  output logic ready_o,
  input wire logic [rv_isa_pkg::reg_addr_w-1:0] rd_addr_i,
  input wire logic [rv_isa_pkg::xlen-1:0] result_i,
  input wire logic mem_valid_i,
  input wire logic mem_we_i,
  input wire logic [rv_isa_pkg::xlen-1:0] mem_data_i,
  input wire logic bus_ack_i,
  input wire logic bus_stall_i,
  input wire logic [rv_isa_pkg::xlen-1:0] bus_rdata_i,
  output logic bus_cyc_o,
  output logic bus_stb_o,
  output logic bus_we_o,
  output logic [rv_bus_pkg::bus_addr_w-1:0] bus_addr_o,
  output logic [rv_bus_pkg::bus_sel_w-1:0] bus_sel_o,
  output logic [rv_isa_pkg::xlen-1:0] bus_wdata_o,
  output logic rf_w_enable_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0] rf_w_addr_o,
  output logic [rv_isa_pkg::xlen-1:0] rf_w_data_o,
  output logic [rv_isa_pkg::reg_addr_w-1:0] hz_rd_o
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  logic valid_q;
  logic [reg_addr_w-1:0] rd_q;
  logic [xlen-1:0] data_q;
  logic take;

  assign ready_o = !bus_cyc_o; // One access at a time
  assign take = valid_i && ready_o;
  assign hz_rd_o = valid_i ? rd_addr_i : '0;

  assign bus_sel_o = sel_full;
  assign rf_w_enable_o = valid_q && rd_q != '0;
  assign rf_w_addr_o = rd_q;
  assign rf_w_data_o = data_q;

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      bus_cyc_o <= 1'b0;
      bus_stb_o <= 1'b0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0; // Write-back is a single cycle
      if (bus_cyc_o) begin
        if (!bus_stall_i) bus_stb_o <= 1'b0;
        if (bus_ack_i) begin
          bus_cyc_o <= 1'b0;
          bus_stb_o <= 1'b0;
          valid_q <= 1'b1;
        end
      end else if (take) begin
        if (mem_valid_i) begin
          bus_cyc_o <= 1'b1;
          bus_stb_o <= 1'b1;
        end else begin
          valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      rd_q <= rd_addr_i;
      data_q <= result_i;
      bus_we_o <= mem_we_i;
      bus_addr_o <= result_i[xlen-1:2];
      bus_wdata_o <= mem_data_i;
    end else if (bus_cyc_o && bus_ack_i && !bus_we_o) begin
      data_q <= bus_rdata_i; // Load data
    end
  end

endmodule

`default_nettype wire

//--- design/rv_bus_arbiter.sv
`timescale 1ns/10ps
`default_nettype none

module rv_bus_arbiter (
  input wire logic clk_i,
  input wire logic reset_ni,
  input wire logic f_cyc_i,
  input wire logic f_stb_i,
  input wire logic [rv_bus_pkg::bus_addr_w-1:0] f_addr_i,
  output logic f_ack_o,
  output logic f_stall_o,
  input wire logic d_cyc_i,
  input wire logic d_stb_i,
  input wire logic d_we_i,
  input wire logic [rv_bus_pkg::bus_addr_w-1:0] d_addr_i,
  input wire logic [rv_bus_pkg::bus_sel_w-1:0] d_sel_i,
  input wire logic [rv_isa_pkg::xlen-1:0] d_wdata_i,
  output logic d_ack_o,
  output logic d_stall_o,
  output logic bus_cyc_o,
  output logic bus_stb_o,
  output logic bus_we_o,
  output logic [rv_bus_pkg::bus_addr_w-1:0] bus_addr_o,
  output logic [rv_bus_pkg::bus_sel_w-1:0] bus_sel_o,
  output logic [rv_isa_pkg::xlen-1:0] bus_wdata_o,
  input wire logic bus_ack_i,
  input wire logic bus_stall_i
);
  import rv_bus_pkg::*;

  logic busy_q;
  logic owner_q; // High for data master
  logic hold;
  logic gnt_d;

  // Keep the owner until its cyc drops, else data master first
  assign hold = busy_q && (owner_q ? d_cyc_i : f_cyc_i);
  assign gnt_d = hold ? owner_q : d_cyc_i;

  always_ff @(posedge clk_i) begin
    if (!reset_ni) begin
      busy_q <= 1'b0;
      owner_q <= 1'b0;
    end else begin
      busy_q <= gnt_d ? d_cyc_i : f_cyc_i;
      owner_q <= gnt_d;
    end
  end

  assign bus_cyc_o = gnt_d ? d_cyc_i : f_cyc_i;
  assign bus_stb_o = gnt_d ? d_stb_i : f_stb_i;
  assign bus_we_o = gnt_d && d_we_i; // Fetch only reads
  assign bus_addr_o = gnt_d ? d_addr_i : f_addr_i;
  assign bus_sel_o = gnt_d ? d_sel_i : sel_full;
  assign bus_wdata_o = gnt_d ? d_wdata_i : '0;

  assign f_ack_o = !gnt_d && bus_ack_i;
  assign f_stall_o = gnt_d || bus_stall_i;
  assign d_ack_o = gnt_d && bus_ack_i;
  assign d_stall_o = !gnt_d || bus_stall_i;

endmodule

`default_nettype wire

//--- design/rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module rv_core (
  input wire logic clk_i,
  input wire logic reset_ni,
  output logic bus_cyc_o,
  output logic bus_stb_o,
  output logic bus_we_o,
  output logic [rv_bus_pkg::bus_addr_w-1:0] bus_addr_o,
  output logic [rv_bus_pkg::bus_sel_w-1:0] bus_sel_o,
  output logic [rv_isa_pkg::xlen-1:0] bus_wdata_o,
  input wire logic bus_ack_i,
  input wire logic bus_stall_i,
  input wire logic [rv_isa_pkg::xlen-1:0] bus_rdata_i
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  logic if2id_valid;
  logic if2id_ready;
  logic [xlen-1:0] if2id_instr;
  logic id2ex_valid;
  logic id2ex_ready;
  logic [reg_addr_w-1:0] id2ex_rd;
  alu_cmd_t id2ex_alu_cmd;
  logic [xlen-1:0] id2ex_lhs;
  logic [xlen-1:0] id2ex_rhs;
  logic id2ex_mem_valid;
  logic id2ex_mem_we;
  logic [xlen-1:0] id2ex_mem_data;
  logic ex2ls_valid;
  logic ex2ls_ready;
  logic [reg_addr_w-1:0] ex2ls_rd;
  logic [xlen-1:0] ex2ls_result;
  logic ex2ls_mem_valid;
  logic ex2ls_mem_we;
  logic [xlen-1:0] ex2ls_mem_data;
  logic [reg_addr_w-1:0] rf_rd0_addr;
  logic [reg_addr_w-1:0] rf_rd1_addr;
  logic [xlen-1:0] rf_rd0_data;
  logic [xlen-1:0] rf_rd1_data;
  logic rf_w_enable;
  logic [reg_addr_w-1:0] rf_w_addr;
  logic [xlen-1:0] rf_w_data;
  logic [reg_addr_w-1:0] hz_ex_rd;
  logic [reg_addr_w-1:0] hz_ls_rd;
  logic f_cyc;
  logic f_stb;
  logic [bus_addr_w-1:0] f_addr;
  logic f_ack;
  logic f_stall;
  logic d_cyc;
  logic d_stb;
  logic d_we;
  logic [bus_addr_w-1:0] d_addr;
  logic [bus_sel_w-1:0] d_sel;
  logic [xlen-1:0] d_wdata;
  logic d_ack;
  logic d_stall;

  rv_fetch u_fetch (
    .clk_i, .reset_ni,
    .instr_ready_i(if2id_ready),
    .instr_valid_o(if2id_valid),
    .instr_o(if2id_instr),
    .pc_o(), // No branches, PC not needed downstream
    .bus_ack_i(f_ack),
    .bus_stall_i(f_stall),
    .bus_rdata_i,
    .bus_cyc_o(f_cyc),
    .bus_stb_o(f_stb),
    .bus_addr_o(f_addr)
  );

  rv_decode u_decode (
    .clk_i, .reset_ni,
    .valid_i(if2id_valid),
    .instr_i(if2id_instr),
    .ready_o(if2id_ready),
    .ready_i(id2ex_ready),
    .valid_o(id2ex_valid),
    .rd_addr_o(id2ex_rd),
    .alu_cmd_o(id2ex_alu_cmd),
    .alu_lhs_o(id2ex_lhs),
    .alu_rhs_o(id2ex_rhs),
    .mem_valid_o(id2ex_mem_valid),
    .mem_we_o(id2ex_mem_we),
    .mem_data_o(id2ex_mem_data),
    .rf_rd0_addr_o(rf_rd0_addr),
    .rf_rd1_addr_o(rf_rd1_addr),
    .rf_rd0_data_i(rf_rd0_data),
    .rf_rd1_data_i(rf_rd1_data),
    .ex_rd_i(hz_ex_rd),
    .ls_rd_i(hz_ls_rd),
    .wb_rd_i(rf_w_addr),
    .wb_valid_i(rf_w_enable)
  );

  rv_regfile u_regfile (
    .clk_i,
    .w_enable_i(rf_w_enable),
    .w_addr_i(rf_w_addr),
    .w_data_i(rf_w_data),
    .rd0_addr_i(rf_rd0_addr),
    .rd1_addr_i(rf_rd1_addr),
    .rd0_data_o(rf_rd0_data),
    .rd1_data_o(rf_rd1_data)
  );

  rv_execute u_execute (
    .clk_i, .reset_ni,
    .valid_i(id2ex_valid),
    .ready_o(id2ex_ready),
    .rd_addr_i(id2ex_rd),
    .alu_cmd_i(id2ex_alu_cmd),
    .alu_lhs_i(id2ex_lhs),
    .alu_rhs_i(id2ex_rhs),
    .mem_valid_i(id2ex_mem_valid),
    .mem_we_i(id2ex_mem_we),
    .mem_data_i(id2ex_mem_data),
    .ready_i(ex2ls_ready),
    .valid_o(ex2ls_valid),
    .rd_addr_o(ex2ls_rd),
    .result_o(ex2ls_result),
    .mem_valid_o(ex2ls_mem_valid),
    .mem_we_o(ex2ls_mem_we),
    .mem_data_o(ex2ls_mem_data),
    .hz_rd_o(hz_ex_rd)
  );

  rv_lsu u_lsu (
    .clk_i, .reset_ni,
    .valid_i(ex2ls_valid),
    .ready_o(ex2ls_ready),
    .rd_addr_i(ex2ls_rd),
    .result_i(ex2ls_result),
    .mem_valid_i(ex2ls_mem_valid),
    .mem_we_i(ex2ls_mem_we),
    .mem_data_i(ex2ls_mem_data),
    .bus_ack_i(d_ack),
    .bus_stall_i(d_stall),
    .bus_rdata_i,
    .bus_cyc_o(d_cyc),
    .bus_stb_o(d_stb),
    .bus_we_o(d_we),
    .bus_addr_o(d_addr),
    .bus_sel_o(d_sel),
    .bus_wdata_o(d_wdata),
    .rf_w_enable_o(rf_w_enable),
    .rf_w_addr_o(rf_w_addr),
    .rf_w_data_o(rf_w_data),
    .hz_rd_o(hz_ls_rd)
  );

  rv_bus_arbiter u_arbiter (
    .clk_i, .reset_ni,
    .f_cyc_i(f_cyc),
    .f_stb_i(f_stb),
    .f_addr_i(f_addr),
    .f_ack_o(f_ack),
    .f_stall_o(f_stall),
    .d_cyc_i(d_cyc),
    .d_stb_i(d_stb),
    .d_we_i(d_we),
    .d_addr_i(d_addr),
    .d_sel_i(d_sel),
    .d_wdata_i(d_wdata),
    .d_ack_o(d_ack),
    .d_stall_o(d_stall),
    .bus_cyc_o, .bus_stb_o, .bus_we_o,
    .bus_addr_o, .bus_sel_o, .bus_wdata_o,
    .bus_ack_i, .bus_stall_i
  );

endmodule

`default_nettype wire

//--- tb/rv_checker.sv
`timescale 1ns/10ps
`default_nettype none

module rv_checker (
  input wire logic clk_i,
  input wire logic reset_ni,
  input wire logic bus_cyc_i,
  input wire logic bus_stb_i,
  input wire logic bus_we_i,
  input wire logic [rv_bus_pkg::bus_addr_w-1:0] bus_addr_i,
  input wire logic [rv_bus_pkg::bus_sel_w-1:0] bus_sel_i,
  input wire logic [rv_isa_pkg::xlen-1:0] bus_wdata_i,
  input wire logic bus_ack_i,
  input wire logic [rv_isa_pkg::xlen-1:0] exp_addr_i,
  input wire logic [rv_isa_pkg::xlen-1:0] exp_data_i,
  input wire logic [3:0] skip_i,
  output logic done_o,
  output logic ok_o,
  output int err_count_o
);
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  localparam logic [bus_addr_w-1:0] data_lo = 30'h80; // Byte address 0x200
  localparam logic [bus_addr_w-1:0] data_hi = 30'hff;
  localparam logic [bus_sel_w-1:0] sel_exp = 4'hf; // Word accesses only

  logic armed;
  logic [3:0] seen;
  logic write_ack;
  int errs = 0;

  assign write_ack = bus_cyc_i && bus_ack_i && bus_we_i;
  assign err_count_o = errs;

  always @(posedge clk_i) begin
    done_o <= 1'b0;
    if (!reset_ni) begin
      armed <= 1'b1; // Re-armed for each test
      seen <= '0;
      ok_o <= 1'b1;
    end else begin
      if (bus_stb_i && !bus_cyc_i) begin
        $display("%0t: stb is high while cyc is low", $time);
        errs = errs + 1;
        ok_o <= 1'b0;
      end
      if (bus_cyc_i && bus_ack_i && bus_sel_i != sel_exp) begin
        $display("mismatch at %0t: bus_sel expected %h got %h", $time,
                 sel_exp, bus_sel_i);
        errs = errs + 1;
        ok_o <= 1'b0;
      end
      if (write_ack && (bus_addr_i < data_lo || bus_addr_i > data_hi)) begin
        $display("%0t: write to word %h outside the data region", $time, bus_addr_i);
        errs = errs + 1;
        ok_o <= 1'b0;
      end
      if (write_ack && armed) begin
        seen <= seen + 1'b1;
        if (seen == skip_i) begin // The store under test
          armed <= 1'b0;
          done_o <= 1'b1;
          if (bus_addr_i != exp_addr_i[xlen-1:2]) begin
            $display("mismatch at %0t: bus_addr expected %h got %h", $time,
                     exp_addr_i[xlen-1:2], bus_addr_i);
            errs = errs + 1;
            ok_o <= 1'b0;
          end
          if (bus_wdata_i != exp_data_i) begin
            $display("mismatch at %0t: bus_wdata expected %h got %h", $time,
                     exp_data_i, bus_wdata_i);
            errs = errs + 1;
            ok_o <= 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb/tb_rv_core.sv
`timescale 1ns/10ps
`default_nettype none

module tb_rv_core;
  import rv_isa_pkg::*;
  import rv_bus_pkg::*;

  localparam int n_tests = 12;
  localparam int mem_words = 256;
  localparam int prog_words = 64; // Instruction area below the data

  logic clk_i = 1'b0;
  logic reset_ni;
  logic bus_cyc;
  logic bus_stb;
  logic bus_we;
  logic [bus_addr_w-1:0] bus_addr;
  logic [bus_sel_w-1:0] bus_sel;
  logic [xlen-1:0] bus_wdata;
  logic bus_ack;
  logic bus_stall;
  logic [xlen-1:0] bus_rdata;
  logic mem_busy;
  logic chk_done;
  logic chk_ok;
  int chk_errs;

  logic [xlen-1:0] mem [mem_words];

  // Test table with one row per test
  logic [xlen-1:0] prog [n_tests][8];
  int prog_len [n_tests];
  logic [xlen-1:0] exp_addr [n_tests];
  logic [xlen-1:0] exp_data [n_tests];
  logic [3:0] exp_skip [n_tests];
  string test_name [n_tests];
  int rows;
  int cur;
  logic [xlen-1:0] cur_addr;
  logic [xlen-1:0] cur_data;
  logic [3:0] cur_skip;
  int passed;
  int failed;

  rv_core u_dut (
    .clk_i, .reset_ni,
    .bus_cyc_o(bus_cyc),
    .bus_stb_o(bus_stb),
    .bus_we_o(bus_we),
    .bus_addr_o(bus_addr),
    .bus_sel_o(bus_sel),
    .bus_wdata_o(bus_wdata),
    .bus_ack_i(bus_ack),
    .bus_stall_i(bus_stall),
    .bus_rdata_i(bus_rdata)
  );

  rv_checker u_checker (
    .clk_i, .reset_ni,
    .bus_cyc_i(bus_cyc),
    .bus_stb_i(bus_stb),
    .bus_we_i(bus_we),
    .bus_addr_i(bus_addr),
    .bus_sel_i(bus_sel),
    .bus_wdata_i(bus_wdata),
    .bus_ack_i(bus_ack),
    .exp_addr_i(cur_addr),
    .exp_data_i(cur_data),
    .skip_i(cur_skip),
    .done_o(chk_done),
    .ok_o(chk_ok),
    .err_count_o(chk_errs)
  );

  function automatic logic [31:0] itype(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] utype(input logic [4:0] rd, input logic [19:0] imm);
    return {imm, rd, op_lui};
  endfunction

  function automatic logic [31:0] stype(input logic [4:0] rs2, input logic [4:0] rs1,
                                        input logic [11:0] imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], op_store}; // SW only
  endfunction

  task automatic new_row(input string nm, input logic [31:0] addr, input logic [31:0] data,
                         input logic [3:0] skip);
    test_name[rows] = nm;
    exp_addr[rows] = addr;
    exp_data[rows] = data;
    exp_skip[rows] = skip;
    prog_len[rows] = 0;
    rows++;
  endtask

  task automatic append_word(input logic [31:0] w);
    prog[rows-1][prog_len[rows-1]] = w;
    prog_len[rows-1]++;
  endtask

  task automatic build_table();
    new_row("lui", 32'h200, 32'habcde000, 4'd0);
    append_word(utype(5'd1, 20'habcde));
    append_word(stype(5'd1, 5'd0, 12'h200));
    new_row("addi", 32'h204, 32'h0000005f, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'hffb)); // -5
    append_word(itype(op_imm, 3'b000, 5'd2, 5'd1, 12'd100));
    append_word(stype(5'd2, 5'd0, 12'h204));
    new_row("slti", 32'h208, 32'h00000001, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'hffd)); // -3
    append_word(itype(op_imm, 3'b010, 5'd2, 5'd1, 12'd1));
    append_word(stype(5'd2, 5'd0, 12'h208));
    new_row("sltiu", 32'h20c, 32'h00000001, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'hffd));
    append_word(itype(op_imm, 3'b011, 5'd2, 5'd1, 12'hfff)); // Compares with all ones
    append_word(stype(5'd2, 5'd0, 12'h20c));
    new_row("xori", 32'h210, 32'hedcbafff, 4'd0);
    append_word(utype(5'd1, 20'h12345));
    append_word(itype(op_imm, 3'b100, 5'd2, 5'd1, 12'hfff));
    append_word(stype(5'd2, 5'd0, 12'h210));
    new_row("ori", 32'h214, 32'h000005aa, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'h500));
    append_word(itype(op_imm, 3'b110, 5'd2, 5'd1, 12'h0aa));
    append_word(stype(5'd2, 5'd0, 12'h214));
    new_row("andi", 32'h218, 32'h000005a5, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'hfff));
    append_word(itype(op_imm, 3'b111, 5'd2, 5'd1, 12'h5a5));
    append_word(stype(5'd2, 5'd0, 12'h218));
    new_row("slli", 32'h21c, 32'hc0000000, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'd3));
    append_word(itype(op_imm, 3'b001, 5'd2, 5'd1, 12'd30));
    append_word(stype(5'd2, 5'd0, 12'h21c));
    new_row("srli", 32'h220, 32'h08000000, 4'd0);
    append_word(utype(5'd1, 20'h80000));
    append_word(itype(op_imm, 3'b101, 5'd2, 5'd1, 12'd4));
    append_word(stype(5'd2, 5'd0, 12'h220));
    new_row("dependent chain", 32'h224, 32'h0000000a, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'd1));
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd1, 12'd2));
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd1, 12'd3));
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd1, 12'd4));
    append_word(stype(5'd1, 5'd0, 12'h224));
    // Second store carries the loaded value
    new_row("load round trip", 32'h22c, 32'h00000331, 4'd1);
    append_word(itype(op_imm, 3'b000, 5'd1, 5'd0, 12'h321));
    append_word(stype(5'd1, 5'd0, 12'h228));
    append_word(itype(op_load, 3'b010, 5'd2, 5'd0, 12'h228));
    append_word(itype(op_imm, 3'b000, 5'd3, 5'd2, 12'h010));
    append_word(stype(5'd3, 5'd0, 12'h22c));
    new_row("x0 write", 32'h230, 32'h00000000, 4'd0);
    append_word(itype(op_imm, 3'b000, 5'd0, 5'd0, 12'h055));
    append_word(stype(5'd0, 5'd0, 12'h230));
  endtask

  task automatic load_program(input int t);
    logic [31:0] av;
    for (int a = 0; a < mem_words; a++) begin
      av = a;
      mem[a] = {~av[15:0], av[15:0]};
    end
    for (int a = 0; a < prog_words; a++) begin
      // Last store repeats to the end of the instruction area
      mem[a] = (a < prog_len[t]) ? prog[t][a] : prog[t][prog_len[t]-1];
    end
  endtask

  task automatic apply_reset(input int t);
    reset_ni = 1'b0;
    repeat (2) @(negedge clk_i);
    while (mem_busy) @(negedge clk_i); // Let a bus cycle in flight drain
    load_program(t);
    reset_ni = 1'b1;
  endtask

  initial begin
    forever #2 clk_i = ~clk_i;
  end

  // Memory model with random wait states
  initial begin : bus_memory
    logic [bus_addr_w-1:0] addr;
    logic we;
    logic [xlen-1:0] wdata;
    int stall_n;
    int ack_n;
    void'($urandom(32'hdd29));
    forever begin
      @(negedge clk_i);
      if (reset_ni && bus_cyc && bus_stb) begin
        mem_busy = 1'b1;
        addr = bus_addr;
        we = bus_we;
        wdata = bus_wdata;
        stall_n = $urandom % 3;
        ack_n = $urandom % 4;
        repeat (stall_n) @(negedge clk_i);
        bus_stall = 1'b0; // Accepted here
        repeat (ack_n) @(negedge clk_i);
        bus_ack = 1'b1;
        bus_rdata = mem[addr[7:0]];
        if (we) mem[addr[7:0]] = wdata;
        @(negedge clk_i);
        bus_ack = 1'b0;
        bus_stall = 1'b1;
        mem_busy = 1'b0;
      end
    end
  end

  initial begin : main
    reset_ni = 1'b0;
    bus_ack = 1'b0;
    bus_stall = 1'b1; // Idle bus holds off new requests
    bus_rdata = '0;
    mem_busy = 1'b0;
    rows = 0;
    cur = 0;
    passed = 0;
    failed = 0;
    build_table();
    for (int t = 0; t < rows; t++) begin
      cur = t;
      cur_addr = exp_addr[t];
      cur_data = exp_data[t];
      cur_skip = exp_skip[t];
      apply_reset(t);
      while (!chk_done) @(negedge clk_i);
      if (chk_ok) passed++;
      else failed++;
      $display("%0t: test %0d %s %s", $time, t, test_name[t], chk_ok ? "ok" : "failed");
    end
    $display("tests passed %0d, failed %0d, errors %0d", passed, failed, chk_errs);
    if (failed == 0 && chk_errs == 0 && passed == rows) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  initial begin
    #(n_tests * 400 * 4);
    $display("timeout, test %0d %s made no checked store", cur, test_name[cur]);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
design/rv_isa_pkg.sv
design/rv_bus_pkg.sv
design/rv_fetch.sv
design/rv_regfile.sv
design/rv_decode.sv
design/rv_execute.sv
design/rv_lsu.sv
design/rv_bus_arbiter.sv
design/rv_core.sv
tb/rv_checker.sv
tb/tb_rv_core.sv
